// File: clkgen.f
src/clkgen_csr_pkg.sv
src/clkgen_prog_pkg.sv
src/clkgen_sync.sv
src/clkgen_csr.sv
src/clkgen_prog_ctrl.sv
src/clkgen_top.sv
test/synth_model.sv
test/clkgen_sva.sv
test/clkgen_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the clkgen testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f clkgen.f \
    --top-module clkgen_tb \
    --Mdir obj_dir \
    -o clkgen_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/clkgen_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// File: src/clkgen_csr.sv
`timescale 1ns/1ns

module clkgen_csr
    import clkgen_csr_pkg::*;
    import clkgen_prog_pkg::*;
(
    input  logic        apb_clk,
    input  logic        apb_rst,
    input  logic [31:0] apb_addr,
    input  logic        apb_sel,
    input  logic        apb_enable,
    input  logic        apb_write,
    input  logic [31:0] apb_wdata,
    input  logic [3:0]  apb_strb,
    output logic        apb_ready,
    output logic [31:0] apb_rdata,
    output logic        apb_int_out,
    input  ctrl_state_t state,
    input  logic        prog_done_r,
    input  logic        obs_rst_in,
    input  logic        obs_out_rst,
    input  logic        obs_synth_rst,
    input  logic        obs_locked,
    input  logic        obs_stopped,
    output logic        ctrl_enable,
    output logic        use_defaults,
    output logic        ignore_stopped,
    output logic        synth_ready,
    output md_value_t   mult,
    output md_value_t   div
);

    csr_addr_t   csr_addr;
    logic        wr_setup;
    logic        rd_setup;
    logic [31:0] wr_mask;
    logic        obs_out_rst_prev;
    logic        status_ready;
    logic        set_enabled;
    logic        set_disabled;
    int_vec_t    int_flags;
    int_vec_t    int_select;
    logic [31:0] csr_control;
    logic [31:0] csr_status;

    assign csr_addr = apb_addr[4:2];

    // writes land at the setup edge
    assign wr_setup = apb_sel && !apb_enable && apb_write;
    assign rd_setup = apb_sel && !apb_enable && !apb_write;
    assign wr_mask  = {32{wr_setup}} &
                      {{8{apb_strb[3]}}, {8{apb_strb[2]}}, {8{apb_strb[1]}}, {8{apb_strb[0]}}};

    assign synth_ready = !obs_synth_rst && obs_locked && (!obs_stopped || ignore_stopped);

    // output reset falling means locked and running
    assign set_enabled  = !obs_out_rst && obs_out_rst_prev;
    assign set_disabled = (obs_out_rst && !obs_out_rst_prev) || (ctrl_enable && obs_rst_in);

    always_ff @(posedge apb_clk) begin
        if (apb_rst) begin
            ctrl_enable      <= default_enable;
            use_defaults     <= 1'b0;
            ignore_stopped   <= 1'b0;
            status_ready     <= 1'b0;
            obs_out_rst_prev <= 1'b1;
        end else begin
            obs_out_rst_prev <= obs_out_rst;
            if (csr_addr == reg_control) begin
                if (wr_mask[0]) ctrl_enable    <= apb_wdata[0];
                if (wr_mask[1]) use_defaults   <= apb_wdata[1];
                if (wr_mask[2]) ignore_stopped <= apb_wdata[2];
            end
            if (set_enabled) begin
                status_ready <= 1'b1;
            end
            if (set_disabled) begin
                status_ready <= 1'b0;
                // without auto-enable, software must re-enable by hand
                if (!default_enable) ctrl_enable <= 1'b0;
            end
        end
    end

    // interrupts
    always_ff @(posedge apb_clk) begin
        if (apb_rst) begin
            int_flags   <= '0;
            int_select  <= '0;
            apb_int_out <= 1'b0;
        end else begin
            if (csr_addr == reg_int_flags) begin
                int_flags <= int_flags & ~(wr_mask[1:0] & apb_wdata[1:0]);
            end
            if (csr_addr == reg_int_select) begin
                int_select <= (int_select & ~wr_mask[1:0]) | (apb_wdata[1:0] & wr_mask[1:0]);
            end
            if (set_enabled)  int_flags[0] <= 1'b1;   // events win over a clear
            if (set_disabled) int_flags[1] <= 1'b1;
            apb_int_out <= |(int_flags & int_select);
        end
    end

    // ratio registers, frozen while enabled
    always_ff @(posedge apb_clk) begin
        if (apb_rst) begin
            mult <= md_value_t'(default_multiply - 1);
            div  <= md_value_t'(default_divide - 1);
        end else if (!ctrl_enable) begin
            if (csr_addr == reg_multiply) begin
                mult <= (mult & ~wr_mask[7:0]) | (apb_wdata[7:0] & wr_mask[7:0]);
            end
            if (csr_addr == reg_divide) begin
                div <= (div & ~wr_mask[7:0]) | (apb_wdata[7:0] & wr_mask[7:0]);
            end
        end
    end

    assign csr_control = {29'd0, ignore_stopped, use_defaults, ctrl_enable};

    assign csr_status = {16'd0, state, 3'd0, prog_done_r,
                         synth_ready, obs_stopped, obs_locked, obs_synth_rst,
                         obs_out_rst, obs_rst_in, apb_int_out, status_ready};

    // zero wait states, ready in the first access cycle
    always_ff @(posedge apb_clk) begin
        if (apb_rst) begin
            apb_ready <= 1'b0;
        end else begin
            apb_ready <= apb_sel && !apb_enable;
        end
    end

    always_ff @(posedge apb_clk) begin
        apb_rdata <= '0;
        if (rd_setup) begin
            case (csr_addr)
                reg_control:    apb_rdata       <= csr_control;
                reg_status:     apb_rdata       <= csr_status;
                reg_int_flags:  apb_rdata[1:0]  <= int_flags;
                reg_int_select: apb_rdata[1:0]  <= int_select;
                reg_multiply:   apb_rdata[7:0]  <= mult;
                reg_divide:     apb_rdata[7:0]  <= div;
                default:        apb_rdata       <= '0;   // unmapped reads as zero
            endcase
        end
    end

endmodule

// File: src/clkgen_csr_pkg.sv
package clkgen_csr_pkg;

    // register index, apb_addr[4:2]
    typedef logic [2:0] csr_addr_t;

    // holds M-1 or D-1
    typedef logic [7:0] md_value_t;

    // bit 0 enabled event, bit 1 disabled event
    typedef logic [1:0] int_vec_t;

    localparam csr_addr_t reg_control    = 3'd0;
    localparam csr_addr_t reg_status     = 3'd1;
    localparam csr_addr_t reg_int_flags  = 3'd2;   // write 1 to clear
    localparam csr_addr_t reg_int_select = 3'd3;
    localparam csr_addr_t reg_multiply   = 3'd4;   // locked while enabled
    localparam csr_addr_t reg_divide     = 3'd5;   // locked while enabled

    // synthesizer power-up ratio
    localparam int default_multiply = 4;
    localparam int default_divide   = 1;

    // control enable bit after reset
    localparam logic default_enable = 1'b0;

endpackage

// File: src/clkgen_prog_ctrl.sv
`timescale 1ns/1ns

module clkgen_prog_ctrl
    import clkgen_csr_pkg::*;
    import clkgen_prog_pkg::*;
(
    input  logic        apb_clk,
    input  logic        apb_rst,
    input  logic        ctrl_enable,
    input  logic        use_defaults,
    input  logic        synth_ready,
    input  logic        obs_synth_rst,
    input  logic        obs_out_rst,
    input  logic        prog_done,
    input  md_value_t   mult,
    input  md_value_t   div,
    output ctrl_state_t state,
    output logic        prog_done_r,
    output logic        prog_en,
    output logic        prog_data,
    output logic        synth_rst_req,
    output logic        out_rst_req
);

    localparam wait_cnt_t cnt_last  = wait_cnt_t'(settle_cycles - 1);
    localparam wait_cnt_t word_last = wait_cnt_t'($bits(prog_word_t) - 1);

    ctrl_state_t next_state;
    wait_cnt_t   cnt;
    logic        cnt_clear;
    logic        cnt_max;
    prog_word_t  load_d;
    prog_word_t  load_m;
    logic        next_prog_en;
    logic        next_prog_data;

    assign load_d  = {div, op_load_d};
    assign load_m  = {mult, op_load_m};
    assign cnt_max = (cnt == cnt_last);

    always_ff @(posedge apb_clk) begin
        if (apb_rst) begin
            prog_done_r <= 1'b0;
        end else begin
            prog_done_r <= prog_done;
        end
    end

    // one counter shared by the settle waits and the word shifter
    always_ff @(posedge apb_clk) begin
        if (apb_rst || cnt_clear) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        next_state     = state;
        cnt_clear      = 1'b1;
        next_prog_en   = 1'b0;
        next_prog_data = 1'b0;

        case (state)
            st_disabled: begin
                // synthesizer must be seen in reset first
                if (ctrl_enable && obs_synth_rst) next_state = st_release;
            end
            st_release: begin
                if (prog_done_r && !obs_synth_rst) begin
                    cnt_clear = 1'b0;
                    if (cnt_max) next_state = use_defaults ? st_wait : st_load_d;
                end
            end
            st_load_d: begin
                next_prog_en   = 1'b1;
                next_prog_data = load_d[cnt];
                cnt_clear      = (cnt == word_last);   // post wait starts at 0
                if (cnt == word_last) next_state = st_load_d_post;
            end
            st_load_d_post: begin
                cnt_clear = 1'b0;
                if (cnt_max) next_state = st_load_m;
            end
            st_load_m: begin
                next_prog_en   = 1'b1;
                next_prog_data = load_m[cnt];
                cnt_clear      = (cnt == word_last);
                if (cnt == word_last) next_state = st_load_m_post;
            end
            st_load_m_post: begin
                cnt_clear = 1'b0;
                if (cnt_max) next_state = st_go;
            end
            st_go: begin
                next_prog_en = 1'b1;   // go is a single low bit
                next_state   = st_wait;
            end
            st_wait: begin
                if (prog_done_r && synth_ready) begin
                    cnt_clear = 1'b0;
                    if (cnt_max) next_state = st_locked;
                end
            end
            st_locked: begin
                if (!ctrl_enable) next_state = st_disable;
                if (!synth_ready) next_state = st_disabled;   // lost lock
            end
            st_disable: begin
                // hold the synthesizer until the output reset has landed
                if (obs_out_rst) begin
                    cnt_clear = 1'b0;
                    if (cnt_max) next_state = st_disabled;
                end
            end
            default: next_state = st_disabled;
        endcase

        // disable before lock needs no shutdown
        if (!ctrl_enable && !(state == st_locked || state == st_disable)) begin
            next_state = st_disabled;
        end

        if (obs_synth_rst && !(state == st_disabled || state == st_release)) begin
            next_state = st_disabled;   // external reset
        end
    end

    always_ff @(posedge apb_clk) begin
        if (apb_rst) begin
            state         <= st_disabled;
            prog_en       <= 1'b0;
            prog_data     <= 1'b0;
            synth_rst_req <= 1'b1;
            out_rst_req   <= 1'b1;
        end else begin
            state         <= next_state;
            prog_en       <= next_prog_en;
            prog_data     <= next_prog_data;
            synth_rst_req <= (state == st_disabled);
            out_rst_req   <= (state != st_locked);
        end
    end

endmodule

// File: src/clkgen_prog_pkg.sv
package clkgen_prog_pkg;

    typedef enum logic [3:0] {
        st_disabled    = 4'd0,  // synthesizer held in reset
        st_release     = 4'd1,  // coming out of reset
        st_load_d      = 4'd2,  // shifting divide word
        st_load_d_post = 4'd3,
        st_load_m      = 4'd4,  // shifting multiply word
        st_load_m_post = 4'd5,
        st_go          = 4'd6,
        st_wait        = 4'd7,  // waiting for lock
        st_locked      = 4'd8,  // output reset released
        st_disable     = 4'd9   // output reset applied, shutting down
    } ctrl_state_t;

    // {value, opcode}, shifted lsb first
    typedef logic [9:0] prog_word_t;

    localparam logic [1:0] op_load_d = 2'b01;
    localparam logic [1:0] op_load_m = 2'b11;

    typedef logic [3:0] wait_cnt_t;

    // settle time after release, after each word and before lock
    localparam int settle_cycles = 16;

endpackage

// File: src/clkgen_sync.sv
`timescale 1ns/1ns

module clkgen_sync (
    input  logic apb_clk,
    input  logic apb_rst,
    input  logic gen_clk,
    input  logic rst_in,
    input  logic synth_rst,
    input  logic synth_locked,
    input  logic synth_stopped,
    input  logic out_rst_req,   // already combined with rst_in
    output logic rst,
    output logic obs_rst_in,
    output logic obs_out_rst,
    output logic obs_synth_rst,
    output logic obs_locked,
    output logic obs_stopped
);

    logic [4:0] meta;
    logic [4:0] obs;
    logic [1:0] out_rst_sync;

    // status into apb_clk: {rst_in, rst, synth_rst, stopped, locked}
    always_ff @(posedge apb_clk) begin
        if (apb_rst) begin
            meta <= 5'b11110;   // resets read as asserted, no lock
            obs  <= 5'b11110;
        end else begin
            meta <= {rst_in, rst, synth_rst, synth_stopped, synth_locked};
            obs  <= meta;
        end
    end

    assign {obs_rst_in, obs_out_rst, obs_synth_rst, obs_stopped, obs_locked} = obs;

    // generated clock may be stopped, so assertion cannot wait for an edge
    always_ff @(posedge gen_clk or posedge out_rst_req) begin
        if (out_rst_req) begin
            out_rst_sync <= 2'b11;
        end else begin
            out_rst_sync <= {out_rst_sync[0], 1'b0};   // release after 2 edges
        end
    end

    assign rst = out_rst_sync[1];

endmodule

// File: src/clkgen_top.sv
`timescale 1ns/1ns

module clkgen_top
    import clkgen_csr_pkg::*;
    import clkgen_prog_pkg::*;
(
    input  logic        apb_clk,
    input  logic        apb_rst,
    input  logic [31:0] apb_addr,
    input  logic        apb_sel,
    input  logic        apb_enable,
    input  logic        apb_write,
    input  logic [31:0] apb_wdata,
    input  logic [3:0]  apb_strb,
    output logic        apb_ready,
    output logic [31:0] apb_rdata,
    output logic        apb_int_out,
    input  logic        rst_in,
    input  logic        gen_clk,
    input  logic        synth_locked,
    input  logic        synth_stopped,
    input  logic        prog_done,
    output logic        synth_rst,
    output logic        prog_en,
    output logic        prog_data,
    output logic        rst
);

    ctrl_state_t state;
    md_value_t   mult;
    md_value_t   div;
    logic        ctrl_enable;
    logic        use_defaults;
    logic        ignore_stopped;
    logic        synth_ready;
    logic        prog_done_r;
    logic        obs_rst_in;
    logic        obs_out_rst;
    logic        obs_synth_rst;
    logic        obs_locked;
    logic        obs_stopped;
    logic        synth_rst_req;
    logic        out_rst_req;
    logic        out_rst_src;

    // external reset overrides both requests
    assign synth_rst   = rst_in || synth_rst_req;
    assign out_rst_src = rst_in || out_rst_req;

    clkgen_csr clkgen_csr_inst (
        .apb_clk        (apb_clk),
        .apb_rst        (apb_rst),
        .apb_addr       (apb_addr),
        .apb_sel        (apb_sel),
        .apb_enable     (apb_enable),
        .apb_write      (apb_write),
        .apb_wdata      (apb_wdata),
        .apb_strb       (apb_strb),
        .apb_ready      (apb_ready),
        .apb_rdata      (apb_rdata),
        .apb_int_out    (apb_int_out),
        .state          (state),
        .prog_done_r    (prog_done_r),
        .obs_rst_in     (obs_rst_in),
        .obs_out_rst    (obs_out_rst),
        .obs_synth_rst  (obs_synth_rst),
        .obs_locked     (obs_locked),
        .obs_stopped    (obs_stopped),
        .ctrl_enable    (ctrl_enable),
        .use_defaults   (use_defaults),
        .ignore_stopped (ignore_stopped),
        .synth_ready    (synth_ready),
        .mult           (mult),
        .div            (div)
    );

    clkgen_sync clkgen_sync_inst (
        .apb_clk       (apb_clk),
        .apb_rst       (apb_rst),
        .gen_clk       (gen_clk),
        .rst_in        (rst_in),
        .synth_rst     (synth_rst),
        .synth_locked  (synth_locked),
        .synth_stopped (synth_stopped),
        .out_rst_req   (out_rst_src),
        .rst           (rst),
        .obs_rst_in    (obs_rst_in),
        .obs_out_rst   (obs_out_rst),
        .obs_synth_rst (obs_synth_rst),
        .obs_locked    (obs_locked),
        .obs_stopped   (obs_stopped)
    );

    clkgen_prog_ctrl clkgen_prog_ctrl_inst (
        .apb_clk       (apb_clk),
        .apb_rst       (apb_rst),
        .ctrl_enable   (ctrl_enable),
        .use_defaults  (use_defaults),
        .synth_ready   (synth_ready),
        .obs_synth_rst (obs_synth_rst),
        .obs_out_rst   (obs_out_rst),
        .prog_done     (prog_done),
        .mult          (mult),
        .div           (div),
        .state         (state),
        .prog_done_r   (prog_done_r),
        .prog_en       (prog_en),
        .prog_data     (prog_data),
        .synth_rst_req (synth_rst_req),
        .out_rst_req   (out_rst_req)
    );

endmodule

// File: test/clkgen_sva.sv
`timescale 1ns/1ns

module clkgen_sva
    import clkgen_prog_pkg::*;
(
    input logic        apb_clk,
    input logic        apb_rst,
    input logic        apb_sel,
    input logic        apb_enable,
    input logic        apb_ready,
    input logic        synth_rst,
    input logic        prog_en,
    input logic        rst,
    input ctrl_state_t state
);

    // zero wait states, ready only in the access cycle after setup
    ready_in_access: assert property (@(posedge apb_clk) disable iff (apb_rst)
        apb_ready == (apb_sel && apb_enable))
        else $error("apb_ready is not high exactly in the access cycle after setup");

    no_prog_in_reset: assert property (@(posedge apb_clk) disable iff (apb_rst)
        !(prog_en && synth_rst))
        else $error("prog_en high while synth_rst is high");

    // two cycles of slack for the registered request
    rst_unless_locked: assert property (@(posedge apb_clk) disable iff (apb_rst)
        (state != st_locked && $past(state) != st_locked && $past(state, 2) != st_locked)
        |-> rst)
        else $error("rst low while the controller is not locked");

endmodule

bind clkgen_top clkgen_sva clkgen_sva_inst (
    .apb_clk    (apb_clk),
    .apb_rst    (apb_rst),
    .apb_sel    (apb_sel),
    .apb_enable (apb_enable),
    .apb_ready  (apb_ready),
    .synth_rst  (synth_rst),
    .prog_en    (prog_en),
    .rst        (rst),
    .state      (state)
);

// File: test/clkgen_tb.sv
`timescale 1ns/1ns

module clkgen_tb
    import clkgen_csr_pkg::*;
    import clkgen_prog_pkg::*;
();

    // about 10 us of tests, doubled
    localparam int watchdog_ns = 20000;

    logic        apb_clk = 1'b0;
    logic        apb_rst;
    logic [31:0] apb_addr;
    logic        apb_sel;
    logic        apb_enable;
    logic        apb_write;
    logic [31:0] apb_wdata;
    logic [3:0]  apb_strb;
    logic        apb_ready;
    logic [31:0] apb_rdata;
    logic        apb_int_out;
    logic        rst_in;
    logic        gen_clk;
    logic        synth_locked;
    logic        synth_stopped;
    logic        prog_done;
    logic        synth_rst;
    logic        prog_en;
    logic        prog_data;
    logic        rst;
    logic        model_clk = 1'b0;
    logic        model_locked;
    logic        drop_lock;
    logic [7:0]  rx_d;
    logic [7:0]  rx_m;
    int          word_count;
    int          errors = 0;

    // register shadows
    logic [2:0]  sh_control;
    int_vec_t    sh_flags;
    int_vec_t    sh_select;
    md_value_t   sh_mult;
    md_value_t   sh_div;

    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];

    always #2 apb_clk = ~apb_clk;
    always #10 model_clk = ~model_clk;

    assign synth_locked = model_locked && !drop_lock;

    clkgen_top clkgen_top_inst (.*);

    synth_model synth_model_inst (
        .clk_in     (model_clk),
        .prog_clk   (apb_clk),
        .synth_rst  (synth_rst),
        .prog_en    (prog_en),
        .prog_data  (prog_data),
        .gen_clk    (gen_clk),
        .locked     (model_locked),
        .stopped    (synth_stopped),
        .prog_done  (prog_done),
        .rx_d       (rx_d),
        .rx_m       (rx_m),
        .word_count (word_count)
    );

    function automatic logic [31:0] expected_reg(csr_addr_t idx);
        case (idx)
            reg_control:    return {29'd0, sh_control};
            reg_int_flags:  return {30'd0, sh_flags};
            reg_int_select: return {30'd0, sh_select};
            reg_multiply:   return {24'd0, sh_mult};
            reg_divide:     return {24'd0, sh_div};
            default:        return 32'd0;
        endcase
    endfunction

    function automatic string reg_name(csr_addr_t idx);
        case (idx)
            reg_control:    return "control";
            reg_int_flags:  return "int_flags";
            reg_int_select: return "int_select";
            reg_multiply:   return "multiply";
            reg_divide:     return "divide";
            default:        return "status";
        endcase
    endfunction

    // all fields sit in byte 0
    task automatic update_shadow(csr_addr_t idx, logic [31:0] data, logic [3:0] strb);
        if (strb[0]) begin
            case (idx)
                reg_control:    sh_control = data[2:0];
                reg_int_flags:  sh_flags = sh_flags & ~data[1:0];
                reg_int_select: sh_select = data[1:0];
                reg_multiply:   if (!sh_control[0]) sh_mult = data[7:0];
                reg_divide:     if (!sh_control[0]) sh_div = data[7:0];
                default:        ;
            endcase
        end
    endtask

    task automatic next_cycle();
        @(posedge apb_clk);
        #1;
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic apb_transfer(csr_addr_t idx, logic wr, logic [31:0] data,
                                logic [3:0] strb, output logic [31:0] rdata);
        int n;
        n          = 0;
        apb_addr   = {27'd0, idx, 2'b00};
        apb_sel    = 1'b1;
        apb_enable = 1'b0;
        apb_write  = wr;
        apb_wdata  = data;
        apb_strb   = strb;
        next_cycle();
        apb_enable = 1'b1;
        while (!apb_ready && n < 8) begin
            next_cycle();
            n++;
        end
        assert (apb_ready === 1'b1) else begin
            errors++;
            $display("APB transfer to %s never saw apb_ready", reg_name(idx));
        end
        rdata = apb_rdata;
        next_cycle();
        apb_sel    = 1'b0;
        apb_enable = 1'b0;
        apb_write  = 1'b0;
    endtask

    task automatic apb_write_reg(csr_addr_t idx, logic [31:0] data, logic [3:0] strb);
        logic [31:0] unused;
        apb_transfer(idx, 1'b1, data, strb, unused);
        update_shadow(idx, data, strb);
    endtask

    task automatic apb_read_reg(csr_addr_t idx, output logic [31:0] data);
        apb_transfer(idx, 1'b0, 32'd0, 4'h0, data);
    endtask

    task automatic read_and_check(csr_addr_t idx);
        logic [31:0] d;
        apb_read_reg(idx, d);
        check_value(reg_name(idx), expected_reg(idx), d);
    endtask

    task automatic check_ready_bit(logic exp);
        logic [31:0] d;
        apb_read_reg(reg_status, d);
        check_value("status.ready", {31'd0, exp}, {31'd0, d[0]});
    endtask

    task automatic wait_for_rst(logic level);
        int n;
        n = 0;
        while (rst !== level && n < 1000) begin
            next_cycle();
            n++;
        end
        assert (rst === level) else begin
            errors++;
            $display("timed out waiting for rst to become %0d", level);
        end
    endtask

    always @(posedge apb_clk) begin : compare_reads
        string       n;
        logic [31:0] e;
        logic [31:0] a;
        while (exp_q.size() > 0) begin
            n = name_q.pop_front();
            e = exp_q.pop_front();
            a = act_q.pop_front();
            assert (a === e) else begin
                errors++;
                $display("ERROR t=%0t %s expected %h actual %h", $time, n, e, a);
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("run did not finish within %0d ns", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        csr_addr_t picks [4];
        csr_addr_t idx;
        md_value_t m_val;
        md_value_t d_val;
        int        words_before;
        picks = '{reg_control, reg_int_select, reg_multiply, reg_divide};
        void'($urandom(75851));
        apb_rst    = 1'b1;
        apb_addr   = '0;
        apb_sel    = 1'b0;
        apb_enable = 1'b0;
        apb_write  = 1'b0;
        apb_wdata  = '0;
        apb_strb   = '0;
        rst_in     = 1'b0;
        drop_lock  = 1'b0;
        sh_control = 3'd0;
        sh_flags   = '0;
        sh_select  = '0;
        sh_mult    = md_value_t'(default_multiply - 1);
        sh_div     = md_value_t'(default_divide - 1);
        repeat (8) @(posedge apb_clk);
        #1 apb_rst = 1'b0;
        next_cycle();

        // defaults after reset
        read_and_check(reg_control);
        read_and_check(reg_multiply);
        read_and_check(reg_divide);
        read_and_check(reg_int_flags);
        check_value("rst", 32'd1, {31'd0, rst});
        check_value("apb_int_out", 32'd0, {31'd0, apb_int_out});

        // random writes, lock held off so no events fire
        drop_lock = 1'b1;
        repeat (40) begin
            idx = picks[$urandom % 4];
            apb_write_reg(idx, $urandom, 4'($urandom));
            read_and_check(idx);
        end
        apb_write_reg(reg_control, 32'd0, 4'hf);
        repeat (40) next_cycle();
        drop_lock = 1'b0;
        read_and_check(reg_control);

        // programmed ratio
        m_val = md_value_t'($urandom % 8);
        d_val = md_value_t'($urandom % 4);
        apb_write_reg(reg_multiply, {24'd0, m_val}, 4'h1);
        apb_write_reg(reg_divide, {24'd0, d_val}, 4'h1);
        apb_write_reg(reg_int_select, 32'd1, 4'h1);
        apb_write_reg(reg_control, 32'd1, 4'h1);
        wait_for_rst(1'b0);
        repeat (10) next_cycle();
        check_value("rx_d", {24'd0, d_val}, {24'd0, rx_d});
        check_value("rx_m", {24'd0, m_val}, {24'd0, rx_m});
        sh_flags[0] = 1'b1;
        check_ready_bit(1'b1);
        read_and_check(reg_int_flags);
        check_value("apb_int_out", 32'd1, {31'd0, apb_int_out});

        // disable by software, then clear flags
        apb_write_reg(reg_control, 32'd0, 4'h1);
        wait_for_rst(1'b1);
        repeat (10) next_cycle();
        sh_flags[1] = 1'b1;
        read_and_check(reg_int_flags);
        apb_write_reg(reg_int_flags, 32'd3, 4'h1);
        read_and_check(reg_int_flags);
        check_value("apb_int_out", 32'd0, {31'd0, apb_int_out});
        repeat (40) next_cycle();

        // power-up ratio, no serial words
        words_before = word_count;
        apb_write_reg(reg_control, 32'd3, 4'h1);
        wait_for_rst(1'b0);
        repeat (10) next_cycle();
        check_value("word_count", 32'd0, 32'(word_count - words_before));
        check_ready_bit(1'b1);
        sh_flags[0] = 1'b1;
        read_and_check(reg_int_flags);

        // lock lost while enabled
        drop_lock = 1'b1;
        wait_for_rst(1'b1);
        repeat (10) next_cycle();
        sh_flags[1]   = 1'b1;
        sh_control[0] = 1'b0;   // cleared by the disabled event
        read_and_check(reg_control);
        read_and_check(reg_int_flags);
        check_ready_bit(1'b0);
        drop_lock = 1'b0;

        repeat (4) next_cycle();
        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: test/synth_model.sv
`timescale 1ns/1ns

module synth_model (
    input  logic       clk_in,      // 20 ns reference
    input  logic       prog_clk,    // programming port clock
    input  logic       synth_rst,
    input  logic       prog_en,
    input  logic       prog_data,
    output logic       gen_clk,
    output logic       locked,
    output logic       stopped,
    output logic       prog_done,
    output logic [7:0] rx_d,        // D-1 taken on go
    output logic [7:0] rx_m,        // M-1 taken on go
    output int         word_count
);

    logic [9:0] sr;
    logic [7:0] pend_d;
    logic [7:0] pend_m;
    int         bit_cnt;
    int         go_count;
    int         seen_go;
    int         lock_cnt;
    int         words_at_arm;
    logic       armed;
    logic       from_go;
    logic       rst_prev;

    assign stopped = synth_rst;   // no output clock while in reset

    initial begin
        gen_clk    = 1'b0;
        rx_d       = 8'd0;
        rx_m       = 8'd3;
        word_count = 0;
        go_count   = 0;
        seen_go    = 0;
        bit_cnt    = 0;
        rst_prev   = 1'b1;
        armed      = 1'b0;
        from_go    = 1'b0;
        locked     = 1'b0;
        prog_done  = 1'b0;
    end

    // period is clk_in period * D / M
    function automatic int half_period();
        int h;
        h = (10 * (int'(rx_d) + 1)) / (int'(rx_m) + 1);
        if (h < 1) h = 1;
        return h;
    endfunction

    always begin
        #(half_period());
        gen_clk = ~gen_clk;
    end

    // serial port decode, lsb first
    always @(posedge prog_clk) begin
        if (synth_rst) begin
            bit_cnt   <= 0;
            prog_done <= 1'b0;
            rx_d      <= 8'd0;   // power-up ratio
            rx_m      <= 8'd3;
        end else if (prog_en) begin
            sr        <= {prog_data, sr[9:1]};
            bit_cnt   <= bit_cnt + 1;
            prog_done <= 1'b0;
        end else begin
            prog_done <= 1'b1;
            if (bit_cnt == 10) begin
                if (sr[1:0] == 2'b01) pend_d <= sr[9:2];
                if (sr[1:0] == 2'b11) pend_m <= sr[9:2];
                word_count <= word_count + 1;
            end else if (bit_cnt == 1 && !sr[9]) begin
                rx_d     <= pend_d;   // go
                rx_m     <= pend_m;
                go_count <= go_count + 1;
            end
            bit_cnt <= 0;
        end
    end

    // lock 10 clk_in cycles after go, or after release with no words
    always @(posedge clk_in) begin
        rst_prev <= synth_rst;
        if (synth_rst) begin
            locked <= 1'b0;
            armed  <= 1'b0;
        end else if (go_count != seen_go) begin
            seen_go  <= go_count;
            armed    <= 1'b1;
            from_go  <= 1'b1;
            lock_cnt <= 0;
        end else if (rst_prev) begin
            armed        <= 1'b1;
            from_go      <= 1'b0;
            lock_cnt     <= 0;
            words_at_arm <= word_count;
        end else if (armed) begin
            if (lock_cnt == 9) begin
                armed <= 1'b0;
                if (from_go || word_count == words_at_arm) locked <= 1'b1;
            end else begin
                lock_cnt <= lock_cnt + 1;
            end
        end
    end

endmodule
